/* verilog/dp_pkg.sv */
`default_nettype none

package dp_pkg;

    localparam int WORD_WIDTH    = 16;
    localparam int OPERAND_WIDTH = 9;
    localparam int D_WIDTH       = 10;   // msb picks bank b
    localparam int RAM_DEPTH     = 64;
    localparam int IO_BASE       = 256;  // same base for read and write ports
    localparam int IO_PORTS      = 2;

    typedef logic [WORD_WIDTH-1:0]    word_t;
    typedef logic [OPERAND_WIDTH-1:0] operand_t;
    typedef logic [D_WIDTH-1:0]       dest_t;

    // codes 8 to 15 behave as nop
    typedef enum logic [3:0] {
        OP_NOP    = 4'd0,
        OP_ADD    = 4'd1,
        OP_SUB    = 4'd2,
        OP_AND    = 4'd3,
        OP_OR     = 4'd4,
        OP_XOR    = 4'd5,
        OP_PASS_A = 4'd6,
        OP_MUL    = 4'd7    // low half of product
    } opcode_t;

    typedef struct packed {
        opcode_t  op;
        dest_t    d;
        operand_t a;
        operand_t b;
    } instr_t;

    typedef struct packed {
        logic                a_ram;
        logic                b_ram;
        logic [IO_PORTS-1:0] a_io;   // one-hot
        logic [IO_PORTS-1:0] b_io;   // one-hot
    } dest_sel_t;

endpackage

`default_nettype wire

/* verilog/pipe_delay.sv */
`timescale 1ns/10ps
`default_nettype none

module pipe_delay #(
    parameter int  DEPTH     = 1,
    parameter type payload_t = logic
) (
    input  wire           clock,
    input  wire           reset,
    input  wire payload_t in,
    output payload_t      out
);

    payload_t stage [DEPTH];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < DEPTH; i++) begin
                stage[i] <= '0;
            end
        end else begin
            stage[0] <= in;
            for (int i = 1; i < DEPTH; i++) begin
                stage[i] <= stage[i-1];
            end
        end
    end

    assign out = stage[DEPTH-1];

endmodule

`default_nettype wire

/* verilog/issue_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module issue_stage #(
    parameter int IO_BASE  = dp_pkg::IO_BASE,
    parameter int IO_PORTS = dp_pkg::IO_PORTS
) (
    input  wire                    clock,
    input  wire                    reset,
    input  wire dp_pkg::instr_t    instr,
    input  wire                    a_read_blocked,
    input  wire                    b_read_blocked,
    input  wire [IO_PORTS-1:0]     a_io_out_ef,
    input  wire [IO_PORTS-1:0]     b_io_out_ef,
    output dp_pkg::operand_t       a_addr,
    output dp_pkg::operand_t       b_addr,
    output logic                   issue,
    output logic                   io_ready,
    output dp_pkg::instr_t         issued_instr,
    output dp_pkg::dest_sel_t      dest_sel
);
    import dp_pkg::*;

    instr_t    instr_q;
    operand_t  d_low;
    logic      bank_b;
    logic      writes;
    logic      write_blocked;
    dest_sel_t sel;

    // stage 1
    always_ff @(posedge clock) begin
        if (reset)
            instr_q <= '0;
        else
            instr_q <= instr;
    end

    // banks decode the raw addresses themselves
    assign a_addr = instr_q.a;
    assign b_addr = instr_q.b;

    assign d_low  = instr_q.d[OPERAND_WIDTH-1:0];
    assign bank_b = instr_q.d[D_WIDTH-1];
    assign writes = instr_q.op inside {[OP_ADD:OP_MUL]};

    always_comb begin
        sel       = '0;
        sel.a_ram = writes && !bank_b && (d_low < RAM_DEPTH);
        sel.b_ram = writes && bank_b && (d_low < RAM_DEPTH);
        for (int p = 0; p < IO_PORTS; p++) begin
            sel.a_io[p] = writes && !bank_b && (d_low == IO_BASE + p);
            sel.b_io[p] = writes && bank_b && (d_low == IO_BASE + p);
        end
    end

    // full write port counts the same as an empty read port
    assign write_blocked = |(sel.a_io & a_io_out_ef) || |(sel.b_io & b_io_out_ef);

    assign io_ready = !(a_read_blocked || b_read_blocked || write_blocked);
    assign issue    = io_ready;

    // annul into an all-zero nop
    assign issued_instr = io_ready ? instr_q : '0;
    assign dest_sel     = io_ready ? sel : '0;

endmodule

`default_nettype wire

/* verilog/operand_bank.sv */
`timescale 1ns/10ps
`default_nettype none

module operand_bank #(
    parameter int RAM_DEPTH = dp_pkg::RAM_DEPTH,
    parameter int IO_BASE   = dp_pkg::IO_BASE,
    parameter int IO_PORTS  = dp_pkg::IO_PORTS
) (
    input  wire                               clock,
    input  wire                               reset,
    input  wire dp_pkg::operand_t             read_addr,
    input  wire                               issue,
    input  wire [IO_PORTS-1:0]                io_in_ef,
    input  wire dp_pkg::word_t [IO_PORTS-1:0] io_in,
    input  wire                               write_en,
    input  wire dp_pkg::operand_t             write_addr,
    input  wire dp_pkg::word_t                write_data,
    output logic [IO_PORTS-1:0]               io_rden,
    output logic                              read_blocked,
    output dp_pkg::word_t                     read_data
);
    import dp_pkg::*;

    localparam int ADDR_BITS = $clog2(RAM_DEPTH);

    word_t               ram [RAM_DEPTH];
    logic [IO_PORTS-1:0] io_sel;
    logic                ram_hit;
    word_t               io_word;

    assign ram_hit = read_addr < RAM_DEPTH;

    // i/o read port decode and word select
    always_comb begin
        io_sel  = '0;
        io_word = '0;
        for (int p = 0; p < IO_PORTS; p++) begin
            if (read_addr == IO_BASE + p) begin
                io_sel[p] = 1'b1;
                io_word   = io_in[p];
            end
        end
    end

    assign read_blocked = |(io_sel & io_in_ef);
    assign io_rden      = issue ? io_sel : '0;  // consumes the current word

    always_ff @(posedge clock) begin
        if (write_en)
            ram[write_addr[ADDR_BITS-1:0]] <= write_data;
    end

    // read before write when both hit the same word
    always_ff @(posedge clock) begin
        if (reset || !issue)
            read_data <= '0;
        else if (|io_sel)
            read_data <= io_word;
        else if (ram_hit)
            read_data <= ram[read_addr[ADDR_BITS-1:0]];
        else
            read_data <= '0;   // unmapped
    end

    rden_onehot: assert property (@(posedge clock) disable iff (reset)
        $onehot0(io_rden))
        else $error("more than one io_rden active");

    // issue comes from the readiness check in issue_stage
    rden_not_empty: assert property (@(posedge clock) disable iff (reset)
        (io_rden & io_in_ef) == '0)
        else $error("io_rden on an empty port");

endmodule

`default_nettype wire

/* verilog/alu.sv */
`timescale 1ns/10ps
`default_nettype none

module alu (
    input  wire                  clock,
    input  wire                  reset,
    input  wire dp_pkg::opcode_t op,
    input  wire dp_pkg::dest_t   d,
    input  wire dp_pkg::word_t   a,
    input  wire dp_pkg::word_t   b,
    output dp_pkg::word_t        result,
    output dp_pkg::opcode_t      op_out,
    output dp_pkg::dest_t        d_out
);
    import dp_pkg::*;

    word_t                   r;
    logic [2*WORD_WIDTH-1:0] product;

    assign product = a * b;

    always_comb begin
        case (op)
            OP_ADD:    r = a + b;
            OP_SUB:    r = a - b;
            OP_AND:    r = a & b;
            OP_OR:     r = a | b;
            OP_XOR:    r = a ^ b;
            OP_PASS_A: r = a;
            OP_MUL:    r = product[WORD_WIDTH-1:0];
            default:   r = '0;   // nop, codes 8 to 15
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            result <= '0;
            op_out <= OP_NOP;
            d_out  <= '0;
        end else begin
            result <= r;
            op_out <= op;   // undefined codes pass too
            d_out  <= d;
        end
    end

endmodule

`default_nettype wire

/* verilog/write_back.sv */
`timescale 1ns/10ps
`default_nettype none

module write_back #(
    parameter int IO_PORTS = dp_pkg::IO_PORTS
) (
    input  wire                    clock,
    input  wire                    reset,
    input  wire dp_pkg::dest_sel_t dest_sel,
    input  wire dp_pkg::word_t     result,
    input  wire dp_pkg::dest_t     d,
    output logic                   a_write_en,
    output logic                   b_write_en,
    output dp_pkg::operand_t       write_addr,
    output dp_pkg::word_t          write_data,
    output logic [IO_PORTS-1:0]    a_io_wren,
    output logic [IO_PORTS-1:0]    b_io_wren,
    output dp_pkg::word_t          a_io_out,
    output dp_pkg::word_t          b_io_out
);
    import dp_pkg::*;

    always_ff @(posedge clock) begin
        if (reset) begin
            a_write_en <= 1'b0;
            b_write_en <= 1'b0;
            a_io_wren  <= '0;
            b_io_wren  <= '0;
        end else begin
            a_write_en <= dest_sel.a_ram;
            b_write_en <= dest_sel.b_ram;
            a_io_wren  <= dest_sel.a_io;
            b_io_wren  <= dest_sel.b_io;
        end
    end

    // ram port shared by both banks, bank bit already in dest_sel
    always_ff @(posedge clock) begin
        write_addr <= d[OPERAND_WIDTH-1:0];
        write_data <= result;
    end

    // i/o words hold until the next write to that bank
    always_ff @(posedge clock) begin
        if (|dest_sel.a_io)
            a_io_out <= result;
        if (|dest_sel.b_io)
            b_io_out <= result;
    end

    one_strobe: assert property (@(posedge clock) disable iff (reset)
        $onehot0({a_write_en, b_write_en, a_io_wren, b_io_wren}))
        else $error("several write strobes in one cycle");

endmodule

`default_nettype wire

/* verilog/datapath.sv */
`timescale 1ns/10ps
`default_nettype none

module datapath #(
    parameter int RAM_DEPTH = dp_pkg::RAM_DEPTH,
    parameter int IO_BASE   = dp_pkg::IO_BASE,
    parameter int IO_PORTS  = dp_pkg::IO_PORTS
) (
    input  wire                               clock,
    input  wire                               reset,
    input  wire dp_pkg::instr_t               instr,
    input  wire [IO_PORTS-1:0]                a_io_in_ef,
    input  wire dp_pkg::word_t [IO_PORTS-1:0] a_io_in,
    input  wire [IO_PORTS-1:0]                a_io_out_ef,
    output wire [IO_PORTS-1:0]                a_io_rden,
    output wire [IO_PORTS-1:0]                a_io_wren,
    output wire dp_pkg::word_t                a_io_out,
    input  wire [IO_PORTS-1:0]                b_io_in_ef,
    input  wire dp_pkg::word_t [IO_PORTS-1:0] b_io_in,
    input  wire [IO_PORTS-1:0]                b_io_out_ef,
    output wire [IO_PORTS-1:0]                b_io_rden,
    output wire [IO_PORTS-1:0]                b_io_wren,
    output wire dp_pkg::word_t                b_io_out,
    output wire                               io_ready,
    output wire dp_pkg::word_t                result,
    output wire dp_pkg::opcode_t              op_out,
    output wire dp_pkg::dest_t                d_out,
    output wire dp_pkg::word_t                a_read_data
);
    import dp_pkg::*;

    operand_t  a_addr;
    operand_t  b_addr;
    logic      issue;
    logic      a_read_blocked;
    logic      b_read_blocked;
    instr_t    issued_instr;
    instr_t    stage2_instr;   // lines up with the operands
    dest_sel_t dest_sel_s1;
    dest_sel_t dest_sel_alu;   // lines up with result
    word_t     b_read_data;
    logic      a_write_en;
    logic      b_write_en;
    operand_t  write_addr;
    word_t     write_data;

    issue_stage #(.IO_BASE(IO_BASE), .IO_PORTS(IO_PORTS)) issue_stage (
        .clock          (clock),
        .reset          (reset),
        .instr          (instr),
        .a_read_blocked (a_read_blocked),
        .b_read_blocked (b_read_blocked),
        .a_io_out_ef    (a_io_out_ef),
        .b_io_out_ef    (b_io_out_ef),
        .a_addr         (a_addr),
        .b_addr         (b_addr),
        .issue          (issue),
        .io_ready       (io_ready),
        .issued_instr   (issued_instr),
        .dest_sel       (dest_sel_s1)
    );

    operand_bank #(.RAM_DEPTH(RAM_DEPTH), .IO_BASE(IO_BASE), .IO_PORTS(IO_PORTS)) a_bank (
        .clock        (clock),
        .reset        (reset),
        .read_addr    (a_addr),
        .issue        (issue),
        .io_in_ef     (a_io_in_ef),
        .io_in        (a_io_in),
        .write_en     (a_write_en),
        .write_addr   (write_addr),
        .write_data   (write_data),
        .io_rden      (a_io_rden),
        .read_blocked (a_read_blocked),
        .read_data    (a_read_data)
    );

    operand_bank #(.RAM_DEPTH(RAM_DEPTH), .IO_BASE(IO_BASE), .IO_PORTS(IO_PORTS)) b_bank (
        .clock        (clock),
        .reset        (reset),
        .read_addr    (b_addr),
        .issue        (issue),
        .io_in_ef     (b_io_in_ef),
        .io_in        (b_io_in),
        .write_en     (b_write_en),
        .write_addr   (write_addr),
        .write_data   (write_data),
        .io_rden      (b_io_rden),
        .read_blocked (b_read_blocked),
        .read_data    (b_read_data)
    );

    pipe_delay #(.DEPTH(2), .payload_t(dest_sel_t)) dest_delay (
        .clock (clock),
        .reset (reset),
        .in    (dest_sel_s1),
        .out   (dest_sel_alu)
    );

    pipe_delay #(.DEPTH(1), .payload_t(instr_t)) op_delay (
        .clock (clock),
        .reset (reset),
        .in    (issued_instr),
        .out   (stage2_instr)
    );

    alu alu (
        .clock  (clock),
        .reset  (reset),
        .op     (stage2_instr.op),
        .d      (stage2_instr.d),
        .a      (a_read_data),
        .b      (b_read_data),
        .result (result),
        .op_out (op_out),
        .d_out  (d_out)
    );

    write_back #(.IO_PORTS(IO_PORTS)) write_back (
        .clock      (clock),
        .reset      (reset),
        .dest_sel   (dest_sel_alu),
        .result     (result),
        .d          (d_out),
        .a_write_en (a_write_en),
        .b_write_en (b_write_en),
        .write_addr (write_addr),
        .write_data (write_data),
        .a_io_wren  (a_io_wren),
        .b_io_wren  (b_io_wren),
        .a_io_out   (a_io_out),
        .b_io_out   (b_io_out)
    );

endmodule

`default_nettype wire

/* verif/datapath_checker.sv */
`timescale 1ns/10ps
`default_nettype none

module datapath_checker #(
    parameter int RAM_DEPTH = dp_pkg::RAM_DEPTH,
    parameter int IO_BASE   = dp_pkg::IO_BASE,
    parameter int IO_PORTS  = dp_pkg::IO_PORTS
) (
    input  wire                               clock,
    input  wire                               reset,
    input  wire [127:0]                       test_name,
    input  wire dp_pkg::instr_t               instr,
    input  wire [IO_PORTS-1:0]                a_io_in_ef,
    input  wire dp_pkg::word_t [IO_PORTS-1:0] a_io_in,
    input  wire [IO_PORTS-1:0]                a_io_out_ef,
    input  wire [IO_PORTS-1:0]                a_io_rden,
    input  wire [IO_PORTS-1:0]                a_io_wren,
    input  wire dp_pkg::word_t                a_io_out,
    input  wire [IO_PORTS-1:0]                b_io_in_ef,
    input  wire dp_pkg::word_t [IO_PORTS-1:0] b_io_in,
    input  wire [IO_PORTS-1:0]                b_io_out_ef,
    input  wire [IO_PORTS-1:0]                b_io_rden,
    input  wire [IO_PORTS-1:0]                b_io_wren,
    input  wire dp_pkg::word_t                b_io_out,
    input  wire                               io_ready,
    input  wire dp_pkg::word_t                result,
    input  wire dp_pkg::opcode_t              op_out,
    input  wire dp_pkg::dest_t                d_out,
    input  wire dp_pkg::word_t                a_read_data,
    output int                                checks,
    output int                                mismatches
);
    import dp_pkg::*;

    // expected outputs of one instruction, aged one step per cycle
    typedef struct packed {
        logic [127:0]        name;
        logic                ready;
        logic [IO_PORTS-1:0] a_rden;
        logic [IO_PORTS-1:0] b_rden;
        word_t               a_val;
        word_t               res;
        logic [3:0]          op;
        dest_t               d;
        logic [IO_PORTS-1:0] a_wren;
        logic [IO_PORTS-1:0] b_wren;
        logic                a_ram;
        logic                b_ram;
    } entry_t;

    word_t        ram_a [RAM_DEPTH];   // unwritten words stay x like the dut
    word_t        ram_b [RAM_DEPTH];
    entry_t       pipe [1:3];
    entry_t       cur;
    instr_t       s1;
    logic [127:0] s1_name;
    logic         reset_seen;

    initial begin
        checks     = 0;
        mismatches = 0;
        reset_seen = 1'b0;
    end

    task automatic compare_value(input logic [127:0] name, input logic [63:0] field,
                                 input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            mismatches++;
            $display("Mismatch %0s %0s: expected %h, actual %h", name, field, exp, act);
        end
    endtask

    function automatic word_t alu_model(input logic [3:0] op, input word_t a, input word_t b);
        case (op)
            4'd1: return a + b;
            4'd2: return a - b;
            4'd3: return a & b;
            4'd4: return a | b;
            4'd5: return a ^ b;
            4'd6: return a;
            4'd7: return a * b;   // truncated to the word
            default: return '0;
        endcase
    endfunction

    function automatic int io_port(input logic [8:0] addr);
        if (addr >= IO_BASE && addr < IO_BASE + IO_PORTS)
            return addr - IO_BASE;
        return -1;
    endfunction

    // stage 1 view of the instruction registered last cycle
    function automatic entry_t stage_one();
        entry_t     e;
        int         pa;
        int         pb;
        int         pd;
        logic       writes;
        logic       bank_b;
        logic [8:0] low;
        word_t      b_val;
        e      = '0;
        b_val  = '0;
        e.name = s1_name;
        pa     = io_port(s1.a);
        pb     = io_port(s1.b);
        low    = s1.d[8:0];
        bank_b = s1.d[9];
        pd     = io_port(low);
        writes = s1.op >= 4'd1 && s1.op <= 4'd7;
        e.ready = !((pa >= 0 && a_io_in_ef[pa]) || (pb >= 0 && b_io_in_ef[pb]) ||
                    (writes && pd >= 0 && (bank_b ? b_io_out_ef[pd] : a_io_out_ef[pd])));
        if (!e.ready)
            return e;   // annulled into a nop
        if (pa >= 0) begin
            e.a_rden[pa] = 1'b1;
            e.a_val      = a_io_in[pa];
        end else if (s1.a < RAM_DEPTH)
            e.a_val = ram_a[s1.a];
        if (pb >= 0) begin
            e.b_rden[pb] = 1'b1;
            b_val        = b_io_in[pb];
        end else if (s1.b < RAM_DEPTH)
            b_val = ram_b[s1.b];
        e.res = alu_model(s1.op, e.a_val, b_val);
        e.op  = s1.op;
        e.d   = s1.d;
        if (writes && low < RAM_DEPTH) begin
            e.a_ram = !bank_b;
            e.b_ram = bank_b;
        end
        if (writes && pd >= 0) begin
            if (bank_b)
                e.b_wren[pd] = 1'b1;
            else
                e.a_wren[pd] = 1'b1;
        end
        return e;
    endfunction

    task automatic check_idle();
        compare_value("reset", "a_rden", '0, a_io_rden);
        compare_value("reset", "b_rden", '0, b_io_rden);
        compare_value("reset", "a_wren", '0, a_io_wren);
        compare_value("reset", "b_wren", '0, b_io_wren);
        compare_value("reset", "result", '0, result);
        compare_value("reset", "op_out", '0, op_out);
        compare_value("reset", "d_out", '0, d_out);
    endtask

    always @(posedge clock) begin
        if (reset) begin
            if (reset_seen)
                check_idle();   // outputs are known after the first reset edge
            reset_seen = 1'b1;
            pipe[1] = '0;
            pipe[2] = '0;
            pipe[3] = '0;
        end else begin
            cur = stage_one();
            compare_value(s1_name, "io_ready", cur.ready, io_ready);
            compare_value(s1_name, "a_rden", cur.a_rden, a_io_rden);
            compare_value(s1_name, "b_rden", cur.b_rden, b_io_rden);
            compare_value(pipe[1].name, "a_read", pipe[1].a_val, a_read_data);
            compare_value(pipe[2].name, "result", pipe[2].res, result);
            compare_value(pipe[2].name, "op_out", pipe[2].op, op_out);
            compare_value(pipe[2].name, "d_out", pipe[2].d, d_out);
            compare_value(pipe[3].name, "a_wren", pipe[3].a_wren, a_io_wren);
            compare_value(pipe[3].name, "b_wren", pipe[3].b_wren, b_io_wren);
            if (|pipe[3].a_wren)
                compare_value(pipe[3].name, "a_io_out", pipe[3].res, a_io_out);
            if (|pipe[3].b_wren)
                compare_value(pipe[3].name, "b_io_out", pipe[3].res, b_io_out);
            // store lands after the read above, so a read in the same cycle sees old data
            if (pipe[3].a_ram)
                ram_a[pipe[3].d[8:0]] = pipe[3].res;
            if (pipe[3].b_ram)
                ram_b[pipe[3].d[8:0]] = pipe[3].res;
            pipe[3] = pipe[2];
            pipe[2] = pipe[1];
            pipe[1] = cur;
        end
        s1      = reset ? '0 : instr;
        s1_name = test_name;
    end

endmodule

`default_nettype wire

/* verif/datapath_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module datapath_tb;
    import dp_pkg::*;

    localparam int DRAIN    = 6;
    localparam int BANK_B   = 512;   // destination bit 9
    localparam int UNMAPPED = 300;
    localparam logic [4*IO_PORTS-1:0] NONE = '0;

    logic                   clock = 1'b0;
    logic                   reset;
    instr_t                 instr;
    logic [127:0]           test_name;
    logic [IO_PORTS-1:0]    a_io_in_ef;
    word_t [IO_PORTS-1:0]   a_io_in;
    logic [IO_PORTS-1:0]    a_io_out_ef;
    logic [IO_PORTS-1:0]    b_io_in_ef;
    word_t [IO_PORTS-1:0]   b_io_in;
    logic [IO_PORTS-1:0]    b_io_out_ef;
    wire [IO_PORTS-1:0]     a_io_rden;
    wire [IO_PORTS-1:0]     a_io_wren;
    wire word_t             a_io_out;
    wire [IO_PORTS-1:0]     b_io_rden;
    wire [IO_PORTS-1:0]     b_io_wren;
    wire word_t             b_io_out;
    wire                    io_ready;
    wire word_t             result;
    wire opcode_t           op_out;
    wire dest_t             d_out;
    wire word_t             a_read_data;
    int                     checks;
    int                     mismatches;
    int                     cycles = 0;
    int                     limit = 0;
    logic [127:0]           names [$];
    logic [31:0]            words [$];
    logic [4*IO_PORTS-1:0]  flags [$];

    datapath #(.RAM_DEPTH(RAM_DEPTH), .IO_BASE(IO_BASE), .IO_PORTS(IO_PORTS)) dut (.*);

    datapath_checker #(.RAM_DEPTH(RAM_DEPTH), .IO_BASE(IO_BASE), .IO_PORTS(IO_PORTS))
        scoreboard (.*);

    always #50 clock = ~clock;

    always @(posedge clock) begin
        if (!reset)
            cycles++;
        if (cycles > limit && !reset) begin
            $display("timeout: run went past %0d cycles", limit);
            $display("Some tests failed");
            $finish;
        end
    end

    task automatic add_step(input logic [127:0] name, input logic [3:0] op, input int d,
                            input int a, input int b, input logic [4*IO_PORTS-1:0] f);
        names.push_back(name);
        words.push_back({op, d[9:0], a[8:0], b[8:0]});
        flags.push_back(f);
    endtask

    // columns: name, opcode, destination, operand a, operand b,
    // flags {a_in_ef, b_in_ef, a_out_ef, b_out_ef}
    task automatic build_table();
        add_step("load_a0", OP_PASS_A, 0, IO_BASE, UNMAPPED, NONE);
        add_step("load_a1", OP_PASS_A, 1, IO_BASE + 1, UNMAPPED, NONE);
        add_step("load_b0", OP_PASS_A, BANK_B, IO_BASE, UNMAPPED, NONE);
        add_step("load_b1", OP_PASS_A, BANK_B + 1, IO_BASE + 1, UNMAPPED, NONE);
        add_step("unmapped_d", OP_ADD, 64, IO_BASE, IO_BASE + 1, NONE);  // aliases a[0]
        add_step("io_read_b", OP_XOR, BANK_B + 100, UNMAPPED, IO_BASE, NONE);
        add_step("code_9", 4'd9, 1, 0, UNMAPPED, NONE);
        add_step("nop", OP_NOP, 0, 0, 0, NONE);
        add_step("add", OP_ADD, 2, 0, 0, NONE);
        add_step("sub", OP_SUB, 3, 1, 1, NONE);
        add_step("and", OP_AND, BANK_B + 2, 0, 1, NONE);
        add_step("or", OP_OR, BANK_B + 3, 1, 0, NONE);
        add_step("xor", OP_XOR, 4, 0, 0, NONE);
        add_step("mul", OP_MUL, 5, 1, 1, NONE);
        add_step("pass_a", OP_PASS_A, BANK_B + 4, 0, 1, NONE);
        add_step("io_write_a0", OP_ADD, IO_BASE, 2, 0, NONE);
        add_step("io_write_a1", OP_SUB, IO_BASE + 1, 3, 1, NONE);
        add_step("io_write_b0", OP_OR, BANK_B + IO_BASE, 4, 2, NONE);
        add_step("io_write_b1", OP_XOR, BANK_B + IO_BASE + 1, 5, 3, NONE);
        add_step("block_read_a", OP_ADD, 0, IO_BASE, 0, 8'b01_00_00_00);
        add_step("block_read_b", OP_ADD, BANK_B + 1, 0, IO_BASE + 1, 8'b00_10_00_00);
        add_step("block_write_a", OP_PASS_A, IO_BASE + 1, 0, 0, 8'b00_00_10_00);
        add_step("block_write_b", OP_PASS_A, BANK_B + IO_BASE, 1, 0, 8'b00_00_00_01);
        add_step("other_port", OP_ADD, 6, IO_BASE + 1, IO_BASE, 8'b01_10_00_00);
        add_step("keep_a0", OP_PASS_A, UNMAPPED, 0, 0, NONE);
        add_step("keep_a1", OP_PASS_A, UNMAPPED, 1, 1, NONE);
        add_step("keep_b1", OP_OR, UNMAPPED, UNMAPPED, 1, NONE);
        add_step("keep_a6", OP_ADD, UNMAPPED, 6, 0, NONE);
    endtask

    task automatic apply_step(input int i);
        int n;
        n = names.size();
        instr     <= (i < n) ? instr_t'(words[i]) : '0;
        test_name <= (i < n) ? names[i] : "drain";
        // flags follow one cycle later so they line up with stage 1
        {a_io_in_ef, b_io_in_ef, a_io_out_ef, b_io_out_ef} <=
            (i >= 1 && i <= n) ? flags[i-1] : NONE;
        for (int p = 0; p < IO_PORTS; p++) begin
            a_io_in[p] <= $urandom;
            b_io_in[p] <= $urandom;
        end
    endtask

    initial begin
        void'($urandom(13843));
        reset       = 1'b1;
        instr       = '0;
        test_name   = "reset";
        a_io_in_ef  = '0;
        a_io_in     = '0;
        a_io_out_ef = '0;
        b_io_in_ef  = '0;
        b_io_in     = '0;
        b_io_out_ef = '0;
        build_table();
        limit = names.size() + 10;
        repeat (3) @(posedge clock);
        reset <= 1'b0;
        for (int i = 0; i < names.size() + DRAIN; i++) begin
            @(posedge clock);
            apply_step(i);
        end
        @(negedge clock);
        $display("%0d checks, %0d mismatches", checks, mismatches);
        if (mismatches == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
verilog/dp_pkg.sv
verilog/pipe_delay.sv
verilog/issue_stage.sv
verilog/operand_bank.sv
verilog/alu.sv
verilog/write_back.sv
verilog/datapath.sv
verif/datapath_checker.sv
verif/datapath_tb.sv
